// ==== hw/alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

	// Five-bit opcode field as seen on op_select
	typedef logic [4:0] alu_op_t;

	// Bitwise logic
	localparam alu_op_t OP_NOT = 5'b00001;
	localparam alu_op_t OP_AND = 5'b00010;
	localparam alu_op_t OP_OR = 5'b00011;

	// Add group 001xx
	localparam alu_op_t OP_ADD = 5'b00100;
	localparam alu_op_t OP_SUB = 5'b00101;
	localparam alu_op_t OP_NEG = 5'b00111;

	// Iterative units
	localparam alu_op_t OP_MUL = 5'b01000;
	localparam alu_op_t OP_DIV = 5'b01001;

	// Shift group 11xxx
	localparam alu_op_t OP_SHL = 5'b11000;
	localparam alu_op_t OP_SHR = 5'b11001;
	localparam alu_op_t OP_ROL = 5'b11010;
	localparam alu_op_t OP_ROR = 5'b11011;
	localparam alu_op_t OP_SHLA = 5'b11100;
	localparam alu_op_t OP_SHRA = 5'b11101;

	// Flag positions inside the add group
	localparam int OP_SUB_BIT = 0;
	localparam int OP_NEG_BIT = 1;

	// Flag positions inside the shift group
	localparam int OP_RIGHT_BIT = 0;
	localparam int OP_ROT_BIT = 1;
	localparam int OP_ARITH_BIT = 2;

endpackage

`default_nettype wire

// ==== hw/alu_data_pkg.sv ====
`default_nettype none

package alu_data_pkg;

	// Operand width used when the top level is not overridden
	localparam int ALU_WIDTH_DEFAULT = 32;

	// Divide by zero returns an all-ones quotient and A as remainder
	// A restoring divider gives this for free since every trial subtract fits
	// Clearing it forces the quotient to zero for a zero divisor
	localparam bit DIV_ZERO_QUOTIENT_ONES = 1'b1;

endpackage

`default_nettype wire

// ==== hw/alu_step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_step_counter #(
	parameter int WIDTH = 32
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic count_load,
	input wire logic step_enable,
	output logic count_done
);

	// Enough bits to hold WIDTH itself
	localparam int CNT_W = $clog2(WIDTH + 1);

	logic [CNT_W-1:0] steps_left;

	always_ff @(posedge clock) begin
		if (reset) begin
			steps_left <= '0;
		end else if (count_load) begin
			steps_left <= CNT_W'(WIDTH);
		end else if (step_enable && (steps_left != '0)) begin
			steps_left <= steps_left - 1'b1;
		end
	end

	// Both iterative units stop on this
	assign count_done = (steps_left == '0);

endmodule

`default_nettype wire

// ==== hw/alu_logic_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_logic_unit import alu_op_pkg::*; #(
	parameter int WIDTH = 32
) (
	input wire alu_op_t op_reg,
	input wire logic [WIDTH-1:0] a_reg,
	input wire logic [WIDTH-1:0] b_reg,
	output logic [2*WIDTH-1:0] logic_result
);

	localparam int SHAMT_W = $clog2(WIDTH);

	logic [WIDTH-1:0] add_x;
	logic [WIDTH-1:0] add_y;
	logic [WIDTH-1:0] add_sum;
	logic [SHAMT_W-1:0] shamt;
	logic [2*WIDTH-1:0] rot_left;
	logic [2*WIDTH-1:0] rot_right;
	logic [WIDTH-1:0] shift_out;
	logic [WIDTH-1:0] low_result;

	// Negate runs as 0 - A through the same adder
	assign add_x = op_reg[OP_NEG_BIT] ? '0 : a_reg;
	assign add_y = op_reg[OP_NEG_BIT] ? a_reg : b_reg;
	assign add_sum = op_reg[OP_SUB_BIT] ? (add_x - add_y) : (add_x + add_y);

	// Only the low bits of B give the amount
	assign shamt = b_reg[SHAMT_W-1:0];

	// A doubled copy turns a shift into a rotate
	assign rot_left = {a_reg, a_reg} << shamt;
	assign rot_right = {a_reg, a_reg} >> shamt;

	always_comb begin
		if (op_reg[OP_ROT_BIT]) begin
			if (op_reg[OP_RIGHT_BIT])
				shift_out = rot_right[WIDTH-1:0];
			else
				shift_out = rot_left[2*WIDTH-1:WIDTH];
		end else if (op_reg[OP_RIGHT_BIT]) begin
			// Arithmetic right fills with the sign bit
			if (op_reg[OP_ARITH_BIT])
				shift_out = $signed(a_reg) >>> shamt;
			else
				shift_out = a_reg >> shamt;
		end else begin
			// Left shift is the same with or without the arith flag
			shift_out = a_reg << shamt;
		end
	end

	always_comb begin
		case (op_reg)
			OP_NOT: low_result = ~a_reg;
			OP_AND: low_result = a_reg & b_reg;
			OP_OR: low_result = a_reg | b_reg;
			OP_ADD, OP_SUB, OP_NEG: low_result = add_sum;
			OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA: low_result = shift_out;
			// Unknown opcode, MUL and DIV land here
			default: low_result = '0;
		endcase
	end

	assign logic_result = {{WIDTH{1'b0}}, low_result};

endmodule

`default_nettype wire

// ==== hw/alu_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_multiplier #(
	parameter int WIDTH = 32
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic mul_load,
	input wire logic step_enable,
	input wire logic [WIDTH-1:0] a_reg,
	input wire logic [WIDTH-1:0] b_reg,
	output logic [2*WIDTH-1:0] product
);

	logic [WIDTH-1:0] mcand;
	logic [WIDTH-1:0] mplier;
	logic [2*WIDTH-1:0] acc;
	logic [WIDTH:0] partial_sum;

	// Upper half plus multiplicand when the current multiplier bit is set
	// Carry kept in the extra bit
	assign partial_sum = {1'b0, acc[2*WIDTH-1:WIDTH]} + (mplier[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clock) begin
		if (mul_load) begin
			mcand <= a_reg;
			mplier <= b_reg;
		end else if (step_enable) begin
			// Next multiplier bit moves into position 0
			mplier <= mplier >> 1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			acc <= '0;
		end else if (mul_load) begin
			acc <= '0;
		end else if (step_enable) begin
			// Add then shift right one place
			acc <= {partial_sum, acc[WIDTH-1:1]};
		end
	end

	// Full unsigned product once WIDTH steps are done
	assign product = acc;

endmodule

`default_nettype wire

// ==== hw/alu_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_divider import alu_data_pkg::*; #(
	parameter int WIDTH = 32
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic div_load,
	input wire logic step_enable,
	input wire logic [WIDTH-1:0] a_reg,
	input wire logic [WIDTH-1:0] b_reg,
	output logic [WIDTH-1:0] quotient,
	output logic [WIDTH-1:0] remainder
);

	logic [WIDTH-1:0] divisor;
	logic [WIDTH-1:0] part_rem;
	logic [WIDTH-1:0] quot;
	logic [WIDTH:0] shifted;
	logic [WIDTH:0] trial;
	logic fits;
	logic q_bit;

	// Partial remainder gains the next dividend bit from the top of quot
	assign shifted = {part_rem, quot[WIDTH-1]};
	assign trial = shifted - {1'b0, divisor};
	assign fits = (shifted >= {1'b0, divisor});

	// Zero divisor always fits, so the quotient fills with ones
	assign q_bit = fits && (DIV_ZERO_QUOTIENT_ONES || (divisor != '0));

	always_ff @(posedge clock) begin
		if (div_load)
			divisor <= b_reg;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			part_rem <= '0;
			quot <= '0;
		end else if (div_load) begin
			part_rem <= '0;
			// Dividend shifts out of the top as quotient bits shift in
			quot <= a_reg;
		end else if (step_enable) begin
			// Restore by keeping the shifted value when the trial fails
			part_rem <= fits ? trial[WIDTH-1:0] : shifted[WIDTH-1:0];
			quot <= {quot[WIDTH-2:0], q_bit};
		end
	end

	assign quotient = quot;
	assign remainder = part_rem;

endmodule

`default_nettype wire

// ==== hw/alu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer import alu_op_pkg::*; #(
	parameter int WIDTH = 32
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire alu_op_t op_select,
	input wire logic [WIDTH-1:0] a,
	input wire logic [WIDTH-1:0] b,
	input wire logic [2*WIDTH-1:0] logic_result,
	input wire logic [2*WIDTH-1:0] product,
	input wire logic [WIDTH-1:0] quotient,
	input wire logic [WIDTH-1:0] remainder,
	input wire logic count_done,
	output alu_op_t op_reg,
	output logic [WIDTH-1:0] a_reg,
	output logic [WIDTH-1:0] b_reg,
	output logic mul_load,
	output logic div_load,
	output logic count_load,
	output logic step_enable,
	output logic [2*WIDTH-1:0] result,
	output logic finished,
	output logic busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ITERATE,
		ST_COMPLETE
	} state_t;

	state_t state;
	logic take_start;
	logic [2*WIDTH-1:0] result_next;

	// Start only counts while nothing is in flight
	assign take_start = (state == ST_IDLE) && start;

	// Iterative units and counter load on the same edge that samples start
	assign mul_load = take_start && (op_select == OP_MUL);
	assign div_load = take_start && (op_select == OP_DIV);
	assign count_load = mul_load || div_load;

	// One step per cycle until the counter runs out
	assign step_enable = (state == ST_ITERATE) && !count_done;
	assign busy = (state != ST_IDLE);

	// Pick the finished value by the held opcode
	always_comb begin
		case (op_reg)
			OP_MUL: result_next = product;
			// Remainder over quotient
			OP_DIV: result_next = {remainder, quotient};
			default: result_next = logic_result;
		endcase
	end

	// Held operands feed the logic unit for the whole operation
	always_ff @(posedge clock) begin
		if (take_start) begin
			op_reg <= op_select;
			a_reg <= a;
			b_reg <= b;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			finished <= 1'b0;
			result <= '0;
		end else begin
			// Strobe, high for one cycle only
			finished <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (take_start)
						state <= count_load ? ST_ITERATE : ST_COMPLETE;
				end
				ST_ITERATE: begin
					if (count_done)
						state <= ST_COMPLETE;
				end
				ST_COMPLETE: begin
					result <= result_next;
					finished <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_op_pkg::*, alu_data_pkg::*; #(
	parameter int WIDTH = ALU_WIDTH_DEFAULT
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire alu_op_t op_select,
	input wire logic [WIDTH-1:0] a,
	input wire logic [WIDTH-1:0] b,
	output logic [2*WIDTH-1:0] result,
	output logic finished,
	output logic busy
);

	alu_op_t op_reg;
	logic [WIDTH-1:0] a_reg;
	logic [WIDTH-1:0] b_reg;
	logic mul_load;
	logic div_load;
	logic count_load;
	logic step_enable;
	logic count_done;
	logic [2*WIDTH-1:0] logic_result;
	logic [2*WIDTH-1:0] product;
	logic [WIDTH-1:0] quotient;
	logic [WIDTH-1:0] remainder;

	alu_sequencer #(.WIDTH(WIDTH)) u_sequencer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.op_select(op_select),
		.a(a),
		.b(b),
		.logic_result(logic_result),
		.product(product),
		.quotient(quotient),
		.remainder(remainder),
		.count_done(count_done),
		.op_reg(op_reg),
		.a_reg(a_reg),
		.b_reg(b_reg),
		.mul_load(mul_load),
		.div_load(div_load),
		.count_load(count_load),
		.step_enable(step_enable),
		.result(result),
		.finished(finished),
		.busy(busy)
	);

	// Shared step timing for multiply and divide
	alu_step_counter #(.WIDTH(WIDTH)) u_step_counter (
		.clock(clock),
		.reset(reset),
		.count_load(count_load),
		.step_enable(step_enable),
		.count_done(count_done)
	);

	alu_logic_unit #(.WIDTH(WIDTH)) u_logic_unit (
		.op_reg(op_reg),
		.a_reg(a_reg),
		.b_reg(b_reg),
		.logic_result(logic_result)
	);

	// Iterative units capture the raw operands on the start edge
	alu_multiplier #(.WIDTH(WIDTH)) u_multiplier (
		.clock(clock),
		.reset(reset),
		.mul_load(mul_load),
		.step_enable(step_enable),
		.a_reg(a),
		.b_reg(b),
		.product(product)
	);

	alu_divider #(.WIDTH(WIDTH)) u_divider (
		.clock(clock),
		.reset(reset),
		.div_load(div_load),
		.step_enable(step_enable),
		.a_reg(a),
		.b_reg(b),
		.quotient(quotient),
		.remainder(remainder)
	);

endmodule

`default_nettype wire

// ==== test/alu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_sva import alu_op_pkg::*; #(
	parameter int WIDTH = 32
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire alu_op_t op_select,
	input wire logic finished,
	input wire logic busy
);

	// Cycles spent busy before finished for MUL and DIV
	localparam int ITER_CYCLES = WIDTH + 2;

	logic taken;
	logic iterative;

	// A start only counts while the sequencer is idle
	assign taken = start && !busy;
	assign iterative = (op_select == OP_MUL) || (op_select == OP_DIV);

	// Strobe never stretches past one cycle
	finished_single: assert property (@(posedge clock) disable iff (reset)
		finished |=> !finished)
		else $error("finished stayed high for two consecutive cycles");

	// Sequencer returns to idle out of reset
	idle_after_reset: assert property (@(posedge clock)
		reset |=> !busy)
		else $error("busy is high right after reset");

	// Logic, add, shift and unknown opcodes
	one_cycle_latency: assert property (@(posedge clock) disable iff (reset)
		(taken && !iterative) |=> (busy && !finished) ##1 finished)
		else $error("one-cycle operation did not finish one cycle after start");

	// Load, WIDTH steps, then the result cycle
	iterative_latency: assert property (@(posedge clock) disable iff (reset)
		(taken && iterative) |=> (busy && !finished)[*ITER_CYCLES] ##1 finished)
		else $error("multiply or divide did not finish WIDTH+2 cycles after start");

endmodule

// Attach to every alu_top instance
bind alu_top alu_sva #(.WIDTH(WIDTH)) u_sva (
	.clock(clock),
	.reset(reset),
	.start(start),
	.op_select(op_select),
	.finished(finished),
	.busy(busy)
);

`default_nettype wire

// ==== test/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_op_pkg::*, alu_data_pkg::*; ();

	localparam int WIDTH = ALU_WIDTH_DEFAULT;
	localparam int SHAMT_W = $clog2(WIDTH);
	// Cycle budget for any single wait
	localparam int TIMEOUT = 4 * WIDTH;

	logic clock;
	logic reset;
	logic start;
	alu_op_t op_select;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;
	logic [2*WIDTH-1:0] result;
	logic finished;
	logic busy;

	integer seed;
	int errors;
	int checks;
	int tests;
	int test_errors;
	string test_name;

	alu_top #(.WIDTH(WIDTH)) i_dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.op_select(op_select),
		.a(a),
		.b(b),
		.result(result),
		.finished(finished),
		.busy(busy)
	);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Lands 1 ns after the rising edge, where inputs change and outputs are read
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errors = errors;
		tests++;
	endtask

	task automatic close_test();
		$display("%s: done, %0d errors", test_name, errors - test_errors);
	endtask

	task automatic check_result(input logic [2*WIDTH-1:0] expected,
			input logic [2*WIDTH-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_latency(input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("Mismatch in %s latency: expected %0d, actual %0d",
				test_name, expected, actual);
		end
	endtask

	task automatic check_level(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch in %s %s: expected %b, actual %b",
				test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("Mismatch in %s finished count: expected %0d, actual %0d",
				test_name, expected, actual);
		end
	endtask

	// Expected result straight from the opcode rules
	function automatic logic [2*WIDTH-1:0] model(input alu_op_t op,
			input logic [WIDTH-1:0] x, input logic [WIDTH-1:0] y);
		logic [WIDTH-1:0] low;
		logic [2*WIDTH-1:0] wide;
		int amount;
		low = '0;
		wide = '0;
		amount = int'(y[SHAMT_W-1:0]);
		case (op)
			OP_NOT: low = ~x;
			OP_AND: low = x & y;
			OP_OR: low = x | y;
			OP_ADD: low = x + y;
			OP_SUB: low = x - y;
			OP_NEG: low = '0 - x;
			OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA: begin
				low = x;
				// One bit position per pass
				for (int i = 0; i < amount; i++) begin
					if (op[OP_RIGHT_BIT] && op[OP_ROT_BIT])
						low = {low[0], low[WIDTH-1:1]};
					else if (op[OP_RIGHT_BIT] && op[OP_ARITH_BIT])
						low = {low[WIDTH-1], low[WIDTH-1:1]};
					else if (op[OP_RIGHT_BIT])
						low = {1'b0, low[WIDTH-1:1]};
					else if (op[OP_ROT_BIT])
						low = {low[WIDTH-2:0], low[WIDTH-1]};
					else
						low = {low[WIDTH-2:0], 1'b0};
				end
			end
			OP_MUL: wide = {{WIDTH{1'b0}}, x} * {{WIDTH{1'b0}}, y};
			OP_DIV: begin
				// Remainder in the upper half, quotient in the lower
				if (y == '0)
					wide = {x, {WIDTH{DIV_ZERO_QUOTIENT_ONES}}};
				else
					wide = {x % y, x / y};
			end
			default: low = '0;
		endcase
		if (op != OP_MUL && op != OP_DIV)
			wide = {{WIDTH{1'b0}}, low};
		return wide;
	endfunction

	// Pulse start, wait for finished, then compare result and latency
	task automatic run_op(input alu_op_t op, input logic [WIDTH-1:0] op_a,
			input logic [WIDTH-1:0] op_b);
		int cycles;
		int expected_latency;
		cycles = 0;
		expected_latency = (op == OP_MUL || op == OP_DIV) ? WIDTH + 2 : 1;
		op_select = op;
		a = op_a;
		b = op_b;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		while (!finished && cycles < TIMEOUT) begin
			check_level("busy while running", 1'b1, busy);
			next_cycle();
			cycles++;
		end
		if (!finished) begin
			errors++;
			$display("Timeout in %s: finished did not rise within %0d cycles for opcode %b",
				test_name, TIMEOUT, op);
		end else begin
			check_latency(expected_latency, cycles);
			check_result(model(op, op_a, op_b), result);
			check_level("busy with finished", 1'b0, busy);
		end
	endtask

	task automatic test_reset_and_logic();
		logic [WIDTH-1:0] ra;
		logic [WIDTH-1:0] rb;
		open_test("reset_and_logic");
		check_level("finished after reset", 1'b0, finished);
		check_level("busy after reset", 1'b0, busy);
		check_result('0, result);
		for (int i = 0; i < 4; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			run_op(OP_NOT, ra, rb);
			run_op(OP_AND, ra, rb);
			run_op(OP_OR, ra, rb);
		end
		// Unused encoding gives zero in one cycle
		run_op(5'b10101, ra, rb);
		close_test();
	endtask

	task automatic test_add_group();
		logic [WIDTH-1:0] ra;
		logic [WIDTH-1:0] rb;
		open_test("add_group");
		for (int i = 0; i < 4; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			run_op(OP_ADD, ra, rb);
			run_op(OP_SUB, ra, rb);
			run_op(OP_NEG, ra, rb);
		end
		// Wraparound corners
		run_op(OP_ADD, '1, 1);
		run_op(OP_SUB, '0, 1);
		run_op(OP_NEG, '0, '1);
		run_op(OP_NEG, 1, '0);
		run_op(OP_NEG, {1'b1, {(WIDTH-1){1'b0}}}, '0);
		close_test();
	endtask

	task automatic test_shifts();
		alu_op_t shift_ops [6];
		int amounts [4];
		logic [WIDTH-1:0] ra;
		logic [WIDTH-1:0] rb;
		open_test("shifts");
		shift_ops = '{OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA};
		amounts = '{0, 1, WIDTH - 1, -1};
		for (int s = 0; s < 6; s++) begin
			for (int k = 0; k < 4; k++) begin
				for (int n = 0; n < 2; n++) begin
					ra = $random(seed);
					// Second pass keeps the sign bit set
					if (n == 1)
						ra[WIDTH-1] = 1'b1;
					// Upper bits of B are junk the shifter must ignore
					rb = $random(seed);
					if (amounts[k] >= 0)
						rb[SHAMT_W-1:0] = amounts[k];
					run_op(shift_ops[s], ra, rb);
				end
			end
		end
		close_test();
	endtask

	task automatic test_multiply();
		logic [WIDTH-1:0] ra;
		logic [WIDTH-1:0] rb;
		open_test("multiply");
		for (int i = 0; i < 4; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			run_op(OP_MUL, ra, rb);
		end
		run_op(OP_MUL, '1, '1);
		run_op(OP_MUL, '1, 1);
		run_op(OP_MUL, '0, ra);
		run_op(OP_MUL, {1'b1, {(WIDTH-1){1'b0}}}, {1'b1, {(WIDTH-1){1'b0}}});
		close_test();
	endtask

	task automatic test_divide();
		logic [WIDTH-1:0] ra;
		logic [WIDTH-1:0] rb;
		open_test("divide");
		for (int i = 0; i < 4; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			// Shrinking divisors give larger quotients
			rb = rb >> (i * 8);
			run_op(OP_DIV, ra, rb);
		end
		run_op(OP_DIV, ra, 1);
		run_op(OP_DIV, 5, '1);
		run_op(OP_DIV, '1, '1);
		// Zero divisor
		run_op(OP_DIV, ra, '0);
		run_op(OP_DIV, '0, '0);
		close_test();
	endtask

	task automatic test_start_while_busy();
		logic [WIDTH-1:0] ra;
		logic [WIDTH-1:0] rb;
		int elapsed;
		int pulses;
		open_test("start_while_busy");
		ra = $random(seed);
		rb = $random(seed);
		elapsed = 0;
		pulses = 0;
		op_select = OP_MUL;
		a = ra;
		b = rb;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		repeat (3) begin
			next_cycle();
			elapsed++;
		end
		// Second request with other opcode and operands
		op_select = OP_ADD;
		a = $random(seed);
		b = $random(seed);
		start = 1'b1;
		next_cycle();
		elapsed++;
		start = 1'b0;
		// Watch a window well past the multiply latency
		while (elapsed < TIMEOUT) begin
			if (finished) begin
				pulses++;
				if (pulses == 1) begin
					check_latency(WIDTH + 2, elapsed);
					check_result(model(OP_MUL, ra, rb), result);
				end
			end
			next_cycle();
			elapsed++;
		end
		check_count(1, pulses);
		close_test();
	endtask

	initial begin
		seed = 32'haba9_dd3a;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		test_name = "";
		reset = 1'b1;
		start = 1'b0;
		op_select = OP_NOT;
		a = '0;
		b = '0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_and_logic();
		test_add_group();
		test_shifts();
		test_multiply();
		test_divide();
		test_start_while_busy();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/alu_op_pkg.sv
hw/alu_data_pkg.sv
hw/alu_step_counter.sv
hw/alu_logic_unit.sv
hw/alu_multiplier.sv
hw/alu_divider.sv
hw/alu_sequencer.sv
hw/alu_top.sv
test/alu_sva.sv
test/alu_tb.sv
